// File: hdl/vec_in_pkg.sv
`default_nettype none

package vec_in_pkg;

    localparam int data_w = 10;  // memory word width
    localparam int addr_w = 10;  // memory address width

    localparam int op_bit_write = 6;  // position of the write flag in the one-hot op vector

    // op codes carried in the low 3 bits of a command byte
    typedef enum logic [2:0] {
        op_none  = 3'd0,  // no operation, byte is ignored
        op_write = 3'd1,  // load a vector into A or B
        op_read  = 3'd2,
        op_sum   = 3'd3,
        op_avg   = 3'd4,
        op_euc   = 3'd5,  // euclidean distance
        op_man   = 3'd6,  // manhattan distance
        op_dot   = 3'd7   // dot product
    } op_e;

    // one received uart byte, either a command or a data byte
    typedef union packed {
        logic [7:0] raw;            // data view, used by the write controller
        struct packed {
            logic [3:0] rsvd;       // must be zero for a valid command
            logic       bram_sel;   // 0 selects A, 1 selects B
            op_e        op;         // requested operation
        } cmd_view;                 // command view, used by the decoder
    } rx_byte_u;

    // command word handed to the operation stage
    typedef struct packed {
        logic       bram_sel;  // 0 A, 1 B
        logic [6:0] op;        // one-hot, msb first: write read sum avg euc man dot
    } cmd_t;

endpackage

`default_nettype wire

// File: hdl/cmd_decoder.sv
`default_nettype none

module cmd_decoder import vec_in_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     rx_ready,    // one-cycle byte strobe from the uart
    input  wire rx_byte_u rx_data,
    input  wire logic     write_done,  // last word of a write command stored
    input  wire logic     op_done,     // operation stage finished
    output cmd_t          cmd
);

    typedef enum logic {
        st_idle,  // waiting for a command byte
        st_busy   // command held for the write controller or the op stage
    } state_e;

    state_e state;
    logic   cmd_valid;  // acceptable command byte this cycle
    logic   done_hit;   // the done that ends the active command
    op_e    rx_op;

    // op code to one-hot vector, write lands on bit 6, dot on bit 0
    function automatic logic [6:0] op_onehot(input op_e op);
        op_onehot = 7'd0;
        if (op != op_none) begin
            op_onehot = 7'b100_0000 >> (op - 1);
        end
    endfunction

    assign rx_op = rx_data.cmd_view.op;

    assign cmd_valid = rx_ready
                    && (rx_data.cmd_view.rsvd == 4'd0)           // reserved bits clear
                    && (rx_op != op_none)
                    && (!rx_data.cmd_view.bram_sel || rx_op == op_write);  // B is write-only

    // writes finish on the controller's pulse, every other op on op_done
    assign done_hit = cmd.op[op_bit_write] ? write_done : op_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cmd   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_valid) begin
                        cmd.bram_sel <= rx_data.cmd_view.bram_sel;
                        cmd.op       <= op_onehot(rx_op);
                        state        <= st_busy;
                    end
                end
                st_busy: begin  // bytes are data or dropped here, never commands
                    if (done_hit) begin
                        cmd   <= '0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // at most one operation is ever requested
    a_cmd_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(cmd.op))
        else $error("cmd_decoder: op vector not one-hot, %b", cmd.op);

    // the op stage relies on the command not moving under it
    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        (state == st_busy && !done_hit) |=> $stable(cmd))
        else $error("cmd_decoder: cmd changed while busy");

endmodule

`default_nettype wire

// File: hdl/write_ctrl.sv
`default_nettype none

module write_ctrl import vec_in_pkg::*; #(
    parameter int vec_len = 1024  // words per write command
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       rx_ready,  // byte strobe
    input  wire rx_byte_u   rx_data,
    input  wire logic       en,        // write bit of the active command
    input  wire logic       bram_sel,  // 0 A, 1 B
    output logic            write_done,
    output logic            wea_a,
    output logic            wea_b,
    output logic [addr_w-1:0] wr_addr,
    output logic [data_w-1:0] wr_data
);

    localparam logic [addr_w-1:0] last_addr = addr_w'(vec_len - 1);

    logic [7:0] low_byte;  // first byte of the current pair
    logic       phase;     // 0 expecting low byte, 1 expecting high byte
    logic       take_low;
    logic       take_high;

    assign take_low  = en && rx_ready && !phase;
    assign take_high = en && rx_ready && phase;

    // control path, cleared whenever no write command is active
    always_ff @(posedge clk) begin
        if (rst || !en) begin
            phase      <= 1'b0;
            wr_addr    <= '0;   // every write command starts at word 0
            wea_a      <= 1'b0;
            wea_b      <= 1'b0;
            write_done <= 1'b0;
        end else begin
            wea_a      <= take_high && !bram_sel;
            wea_b      <= take_high && bram_sel;
            write_done <= take_high && (wr_addr == last_addr);  // pulses with the last write
            if (take_low) begin
                phase <= 1'b1;
            end else if (take_high) begin
                phase <= 1'b0;
            end
            if (wea_a || wea_b) begin
                wr_addr <= wr_addr + 1'b1;  // next word after each stored one
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (take_low) begin
            low_byte <= rx_data.raw;
        end
        if (take_high) begin
            wr_data <= {rx_data.raw[1:0], low_byte};  // upper 6 bits of the high byte dropped
        end
    end

    // both memories share address and data, so only one may be written
    a_one_bram: assert property (@(posedge clk) disable iff (rst)
        !(wea_a && wea_b))
        else $error("write_ctrl: wea_a and wea_b both high");

    // the last write raises write_done, so the address never runs past the vector
    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        (wea_a || wea_b) |-> (wr_addr < vec_len))
        else $error("write_ctrl: wr_addr %0d out of range", wr_addr);

endmodule

`default_nettype wire

// File: hdl/dual_port_bram.sv
`default_nettype none

module dual_port_bram import vec_in_pkg::*; #(
    parameter int vec_len = 1024  // depth in words
) (
    input  wire logic              clk,
    input  wire logic              we,       // write strobe
    input  wire logic [addr_w-1:0] wr_addr,
    input  wire logic [data_w-1:0] wr_data,
    input  wire logic [addr_w-1:0] rd_addr,
    output logic      [data_w-1:0] rd_data   // valid one cycle after rd_addr
);

    localparam int idx_w = (vec_len > 1) ? $clog2(vec_len) : 1;

    logic [data_w-1:0] mem [vec_len];  // contents undefined until written

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr[idx_w-1:0]] <= wr_data;
        end
    end

    // a same-address write in this cycle still returns the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[idx_w-1:0]];
    end

endmodule

`default_nettype wire

// File: hdl/input_interface.sv
`default_nettype none

module input_interface import vec_in_pkg::*; #(
    parameter int vec_len = 1024  // words per vector
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              rx_ready,          // uart byte strobe
    input  wire rx_byte_u          rx_data,
    input  wire logic              op_done,           // from the operation stage
    input  wire logic [addr_w-1:0] bram_a_read_addr,
    input  wire logic [addr_w-1:0] bram_b_read_addr,
    output cmd_t                   command,           // held until write or op completes
    output logic      [data_w-1:0] bram_a_dout,
    output logic      [data_w-1:0] bram_b_dout
);

    logic              write_done;  // last word of the vector stored
    logic              wea_a;
    logic              wea_b;
    logic [addr_w-1:0] wr_addr;     // shared by both write ports
    logic [data_w-1:0] wr_data;

    cmd_decoder u_cmd_decoder (
        .clk        (clk),
        .rst        (rst),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .write_done (write_done),
        .op_done    (op_done),
        .cmd        (command)
    );

    write_ctrl #(
        .vec_len    (vec_len)
    ) u_write_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data),
        .en         (command.op[op_bit_write]),  // active only for a write command
        .bram_sel   (command.bram_sel),
        .write_done (write_done),
        .wea_a      (wea_a),
        .wea_b      (wea_b),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    dual_port_bram #(
        .vec_len    (vec_len)
    ) bram_a (
        .clk        (clk),
        .we         (wea_a),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (bram_a_read_addr),  // read port owned by the op stage
        .rd_data    (bram_a_dout)
    );

    dual_port_bram #(
        .vec_len    (vec_len)
    ) bram_b (
        .clk        (clk),
        .we         (wea_b),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (bram_b_read_addr),
        .rd_data    (bram_b_dout)
    );

endmodule

`default_nettype wire

// File: bench/input_interface_tb.sv
`default_nettype none

module input_interface_tb import vec_in_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int vec_len    = 8;   // short vectors keep the run quick
    localparam int clk_period = 4;
    localparam int n_steps    = 13;  // reset, 2 writes, 3 readbacks, 6 ops, invalid bytes

    logic              clk;
    logic              rst;
    logic              rx_ready;
    rx_byte_u          rx_data;
    logic              op_done;
    logic [addr_w-1:0] bram_a_read_addr;
    logic [addr_w-1:0] bram_b_read_addr;
    cmd_t              command;
    logic [data_w-1:0] bram_a_dout;
    logic [data_w-1:0] bram_b_dout;

    cmd_t              exp_cmd;           // what command should read at the next edge
    logic              a_check;           // readback of A is live
    logic              b_check;
    logic [data_w-1:0] a_expect;
    logic [data_w-1:0] b_expect;
    logic [data_w-1:0] model_a [vec_len];  // reference contents of A
    logic [data_w-1:0] model_b [vec_len];
    int                cmd_errors;
    int                rd_errors;

    input_interface #(
        .vec_len          (vec_len)
    ) dut (
        .clk              (clk),
        .rst              (rst),
        .rx_ready         (rx_ready),
        .rx_data          (rx_data),
        .op_done          (op_done),
        .bram_a_read_addr (bram_a_read_addr),
        .bram_b_read_addr (bram_b_read_addr),
        .command          (command),
        .bram_a_dout      (bram_a_dout),
        .bram_b_dout      (bram_b_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one-hot layout from the top: write read sum avg euc man dot
    function automatic cmd_t expected_cmd(input op_e code, input logic sel);
        cmd_t c;
        c.bram_sel = sel;
        case (code)
            op_write: c.op = 7'b100_0000;
            op_read:  c.op = 7'b010_0000;
            op_sum:   c.op = 7'b001_0000;
            op_avg:   c.op = 7'b000_1000;
            op_euc:   c.op = 7'b000_0100;
            op_man:   c.op = 7'b000_0010;
            op_dot:   c.op = 7'b000_0001;
            default:  c.op = 7'b000_0000;
        endcase
        return c;
    endfunction

    // one-cycle strobe, called right after a rising edge, returns on the capturing edge
    task automatic strobe_byte(input logic [7:0] b);
        rx_ready    <= 1'b1;
        rx_data.raw <= b;
        @(posedge clk);
        rx_ready    <= 1'b0;
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 1)) @(posedge clk);  // 1 to 3 quiet cycles
    endtask

    // write command then vec_len random words as low/high byte pairs
    task automatic write_vector(input logic sel);
        logic [data_w-1:0] w;
        int                i;
        strobe_byte({4'd0, sel, op_write});
        exp_cmd <= expected_cmd(op_write, sel);  // command appears on this edge
        idle_gap();
        for (i = 0; i < vec_len; i++) begin
            w = data_w'($urandom());
            if (sel) begin
                model_b[i] = w;
            end else begin
                model_a[i] = w;
            end
            strobe_byte(w[7:0]);
            idle_gap();
            strobe_byte({6'($urandom()), w[9:8]});  // junk in the upper 6 bits
            if (i == vec_len - 1) begin
                @(posedge clk);  // write_done edge, command clears one later
                exp_cmd <= '0;
            end
            idle_gap();
        end
    endtask

    // read both ports in lockstep, data lands one cycle after the address
    task automatic read_back(input logic with_b);
        int i;
        for (i = 0; i < vec_len; i++) begin
            bram_a_read_addr <= addr_w'(i);
            bram_b_read_addr <= addr_w'(i);
            @(posedge clk);
            a_check  <= 1'b1;
            b_check  <= with_b;  // B stays unchecked until written
            a_expect <= model_a[i];
            b_expect <= model_b[i];
        end
        @(posedge clk);
        a_check <= 1'b0;
        b_check <= 1'b0;
    endtask

    // non-write op, stray bytes while busy, then op_done
    task automatic run_op(input op_e code);
        int i;
        strobe_byte({4'd0, 1'b0, code});
        exp_cmd <= expected_cmd(code, 1'b0);
        idle_gap();
        for (i = 0; i < 4; i++) begin
            strobe_byte(8'($urandom()));  // dropped, command must hold
            idle_gap();
        end
        op_done <= 1'b1;
        @(posedge clk);
        op_done <= 1'b0;
        exp_cmd <= '0;
        idle_gap();
    endtask

    // bytes the decoder must drop while idle
    task automatic send_invalid();
        int i;
        strobe_byte(8'h00);  // op none
        idle_gap();
        strobe_byte(8'h12);  // reserved field set
        idle_gap();
        strobe_byte(8'h81);  // reserved set on a write
        idle_gap();
        strobe_byte(8'h0a);  // B selected for a read
        idle_gap();
        for (i = 0; i < 6; i++) begin
            strobe_byte({4'hf, 4'($urandom())});  // data-looking bytes
            idle_gap();
        end
    endtask

    initial begin
        int c;
        void'($urandom(32'h3a5b_e41b));
        cmd_errors       = 0;
        rd_errors        = 0;
        rst              = 1'b1;
        rx_ready         = 1'b0;
        rx_data          = '0;
        op_done          = 1'b0;
        bram_a_read_addr = '0;
        bram_b_read_addr = '0;
        exp_cmd          = '0;
        a_check          = 1'b0;
        b_check          = 1'b0;
        a_expect         = '0;
        b_expect         = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle_gap();
        write_vector(1'b0);  // fill A
        read_back(1'b0);
        write_vector(1'b1);  // fill B, A must keep its words
        read_back(1'b1);
        for (c = 2; c <= 7; c++) begin
            run_op(op_e'(c));
        end
        read_back(1'b1);  // ops leave both memories alone
        send_invalid();
        repeat (3) @(posedge clk);
        $display("errors: command %0d, readback %0d", cmd_errors, rd_errors);
        if (cmd_errors == 0 && rd_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(n_steps * 200 * clk_period);
        $display("timeout: run still going after %0d cycles", n_steps * 200);
        $display("TEST FAIL");
        $finish;
    end

    a_command: assert property (@(posedge clk) disable iff (rst)
        command == exp_cmd)
        else begin
            cmd_errors = cmd_errors + 1;
            $display("MISMATCH time=%0t signal=command got=%h expected=%h",
                     $time, $sampled(command), $sampled(exp_cmd));
        end

    a_read_a: assert property (@(posedge clk) disable iff (rst)
        a_check |-> bram_a_dout == a_expect)
        else begin
            rd_errors = rd_errors + 1;
            $display("MISMATCH time=%0t signal=bram_a_dout got=%h expected=%h",
                     $time, $sampled(bram_a_dout), $sampled(a_expect));
        end

    a_read_b: assert property (@(posedge clk) disable iff (rst)
        b_check |-> bram_b_dout == b_expect)
        else begin
            rd_errors = rd_errors + 1;
            $display("MISMATCH time=%0t signal=bram_b_dout got=%h expected=%h",
                     $time, $sampled(bram_b_dout), $sampled(b_expect));
        end

endmodule

`default_nettype wire

// File: src.f
hdl/vec_in_pkg.sv
hdl/cmd_decoder.sv
hdl/write_ctrl.sv
hdl/dual_port_bram.sv
hdl/input_interface.sv
bench/input_interface_tb.sv

// File: run.sh
#!/bin/sh
# build and run the input interface testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module input_interface_tb \
    -o input_interface_sim

# keep the exit status of the simulation, not of tee
./obj_dir/input_interface_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
